//--- rtl/cam_pkg.sv
package cam_pkg;

    // --------------------
    // Bus and data widths
    // --------------------
    localparam int ADDR_W         = 9;
    localparam int DATA_W         = 32;
    localparam int PIX_W          = 8;
    localparam int BYTES_PER_WORD = 4;   // Bytes packed per FIFO word

    // Fixed read values
    localparam logic [31:0] DEVICE_ID     = 32'hF1F0_7E57;
    localparam logic [15:0] REV_NUM       = 16'h0100;
    localparam logic [31:0] DEF_REG_VALUE = 32'hFABD_EFAC;  // Unmapped addresses

    // --------------------
    // Register map
    // --------------------
    localparam logic [8:0] ID_ADR        = 9'h000;
    localparam logic [8:0] REV_ADR       = 9'h001;
    localparam logic [8:0] BANK_BASE_ADR = 9'h040;  // Data port of bank 0
    localparam logic [8:0] BANK_STRIDE   = 9'h040;
    localparam logic [8:0] FLAG_OFS      = 9'h001;  // Flag word follows data port

    // Flag word bits above the 16-bit fill count
    localparam int FLAG_EMPTY_BIT = 16;
    localparam int FLAG_FULL_BIT  = 17;
    localparam int FLAG_OVF_BIT   = 18;

endpackage

//--- rtl/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer #(
    parameter int DEPTH     = 16,
    parameter int NUM_BANKS = 3
) (
    input  logic                       PCLKI,
    input  logic                       WBs_RST_i,
    input  logic                       vsync_i,
    input  logic                       href_i,
    input  logic [cam_pkg::PIX_W-1:0]  pixel_i,
    output logic [cam_pkg::DATA_W-1:0] word_o,
    output logic [NUM_BANKS-1:0]       push_o
);
    import cam_pkg::*;

    localparam int         CNT_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int         BANK_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam logic [1:0] LAST_PHASE = 2'(BYTES_PER_WORD - 1);

    logic                    pix_vld;     // Byte qualified by both syncs
    logic                    word_done;   // Last byte of a word this cycle
    logic [1:0]              byte_phase;
    logic [DATA_W-PIX_W-1:0] shreg;       // Bytes collected so far
    logic [CNT_W-1:0]        word_cnt;    // Words written into current bank
    logic [BANK_W-1:0]       bank_sel;

    assign pix_vld   = vsync_i & href_i;
    assign word_done = pix_vld & (byte_phase == LAST_PHASE);

    // --------------------
    // Byte collection
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            byte_phase <= '0;
        else if (pix_vld)
            byte_phase <= word_done ? 2'd0 : byte_phase + 2'd1;
    end

    // First byte ends up in the top byte of the word
    always_ff @(posedge PCLKI)
    begin
        if (pix_vld)
            shreg <= {shreg[DATA_W-2*PIX_W-1:0], pixel_i};
        if (word_done)
            word_o <= {shreg, pixel_i};  // Held while the next word builds up
    end

    // --------------------
    // Bank rotation
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            push_o   <= '0;
            word_cnt <= '0;
            bank_sel <= '0;
        end
        else
        begin
            // One-cycle strobe to the bank taking this word
            push_o <= word_done ? (NUM_BANKS'(1) << bank_sel) : '0;

            if (word_done)
            begin
                if (word_cnt == CNT_W'(DEPTH - 1))
                begin
                    word_cnt <= '0;
                    if (bank_sel == BANK_W'(NUM_BANKS - 1))
                        bank_sel <= '0;  // Back to bank 0
                    else
                        bank_sel <= bank_sel + 1'b1;
                end
                else
                    word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/fifo_bank.sv
`timescale 1ns/1ps

module fifo_bank #(
    parameter int DEPTH = 16
) (
    input  logic                       PCLKI,
    input  logic                       WBs_RST_i,
    input  logic                       push_i,
    input  logic                       pop_i,
    input  logic [cam_pkg::DATA_W-1:0] word_i,
    output logic [cam_pkg::DATA_W-1:0] head_o,
    output logic [15:0]                count_o,
    output logic                       empty_o,
    output logic                       full_o,
    output logic                       ovf_o
);
    import cam_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));
    assign count_o = 16'(count);
    assign head_o  = empty_o ? '0 : mem[rd_ptr];  // Oldest word, zero when empty

    assign do_push = push_i & ~full_o;   // Push into a full bank is lost
    assign do_pop  = pop_i & ~empty_o;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge PCLKI)
    begin
        if (do_push)
            mem[wr_ptr] <= word_i;
    end

    // --------------------
    // Pointers and flags
    // --------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf_o  <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase

            // Sticky until reset
            if (push_i & full_o)
                ovf_o <= 1'b1;
        end
    end

endmodule

//--- rtl/reg_bus.sv
`timescale 1ns/1ps

module reg_bus #(
    parameter int NUM_BANKS = 3
) (
    input  logic                                 PCLKI,
    input  logic                                 WBs_RST_i,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [cam_pkg::ADDR_W-1:0]           wb_adr_i,
    input  logic [NUM_BANKS*cam_pkg::DATA_W-1:0] head_i,
    input  logic [NUM_BANKS*16-1:0]              count_i,
    input  logic [NUM_BANKS-1:0]                 empty_i,
    input  logic [NUM_BANKS-1:0]                 full_i,
    input  logic [NUM_BANKS-1:0]                 ovf_i,
    output logic [cam_pkg::DATA_W-1:0]           wb_dat_o,
    output logic                                 wb_ack_o,
    output logic [NUM_BANKS-1:0]                 pop_o
);
    import cam_pkg::*;

    logic              req;                      // New bus request
    logic              rd_req;
    logic [DATA_W-1:0] rd_val;
    logic [NUM_BANKS-1:0] pop_sel;              // Data port hit per bank
    logic [DATA_W-1:0] flag_word [NUM_BANKS];

    // Data port address of bank n
    function automatic logic [ADDR_W-1:0] bank_adr(input int n);
        return ADDR_W'(BANK_BASE_ADR + n * BANK_STRIDE);
    endfunction

    assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign rd_req = req & ~wb_we_i;

    // Pop lands on the same edge that samples the head word
    assign pop_o = rd_req ? pop_sel : '0;

    // --------------------
    // Flag words
    // --------------------
    always_comb
    begin
        for (int n = 0; n < NUM_BANKS; n++)
        begin
            flag_word[n]                 = '0;
            flag_word[n][15:0]           = count_i[n*16 +: 16];
            flag_word[n][FLAG_EMPTY_BIT] = empty_i[n];
            flag_word[n][FLAG_FULL_BIT]  = full_i[n];
            flag_word[n][FLAG_OVF_BIT]   = ovf_i[n];
        end
    end

    // --------------------
    // Read decode
    // --------------------
    always_comb
    begin
        rd_val  = DEF_REG_VALUE;
        pop_sel = '0;
        if (wb_adr_i == ID_ADR)
            rd_val = DEVICE_ID;
        if (wb_adr_i == REV_ADR)
            rd_val = {16'h0, REV_NUM};
        for (int n = 0; n < NUM_BANKS; n++)
        begin
            if (wb_adr_i == bank_adr(n))
            begin
                rd_val     = head_i[n*DATA_W +: DATA_W];
                pop_sel[n] = 1'b1;
            end
            if (wb_adr_i == bank_adr(n) + FLAG_OFS)
                rd_val = flag_word[n];
        end
    end

    // Ack one cycle after the request; writes only get the ack
    always_ff @(posedge PCLKI or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end
        else
        begin
            wb_ack_o <= req;
            if (rd_req)
                wb_dat_o <= rd_val;
        end
    end

endmodule

//--- rtl/cam_capture_top.sv
`timescale 1ns/1ps

module cam_capture_top #(
    parameter int DEPTH     = 16,
    parameter int NUM_BANKS = 3
) (
    input  logic                       PCLKI,
    input  logic                       WBs_RST_i,
    input  logic                       vsync_i,
    input  logic                       href_i,
    input  logic [cam_pkg::PIX_W-1:0]  pixel_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [cam_pkg::ADDR_W-1:0] wb_adr_i,
    output logic [cam_pkg::DATA_W-1:0] wb_dat_o,
    output logic                       wb_ack_o
);
    import cam_pkg::*;

    logic [DATA_W-1:0]           word;       // Packed word, shared by all banks
    logic [NUM_BANKS-1:0]        push;
    logic [NUM_BANKS-1:0]        pop;
    logic [NUM_BANKS*DATA_W-1:0] head_all;
    logic [NUM_BANKS*16-1:0]     count_all;
    logic [NUM_BANKS-1:0]        empty_all;
    logic [NUM_BANKS-1:0]        full_all;
    logic [NUM_BANKS-1:0]        ovf_all;

    // --------------------
    // Camera side
    // --------------------
    pixel_packer #(
        .DEPTH     (DEPTH),
        .NUM_BANKS (NUM_BANKS)
    ) u_packer (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .vsync_i   (vsync_i),
        .href_i    (href_i),
        .pixel_i   (pixel_i),
        .word_o    (word),
        .push_o    (push)
    );

    for (genvar n = 0; n < NUM_BANKS; n++)
    begin : g_bank
        fifo_bank #(
            .DEPTH     (DEPTH)
        ) u_bank (
            .PCLKI     (PCLKI),
            .WBs_RST_i (WBs_RST_i),
            .push_i    (push[n]),
            .pop_i     (pop[n]),
            .word_i    (word),
            .head_o    (head_all[n*DATA_W +: DATA_W]),
            .count_o   (count_all[n*16 +: 16]),
            .empty_o   (empty_all[n]),
            .full_o    (full_all[n]),
            .ovf_o     (ovf_all[n])
        );
    end

    // --------------------
    // Register bus
    // --------------------
    reg_bus #(
        .NUM_BANKS (NUM_BANKS)
    ) u_bus (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .head_i    (head_all),
        .count_i   (count_all),
        .empty_i   (empty_all),
        .full_i    (full_all),
        .ovf_i     (ovf_all),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .pop_o     (pop)
    );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 10
) (
    input  logic rst_req_i,   // Rising edge starts a new reset pulse
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held for RST_CYCLES rising edges each time
    initial
    begin
        rst_o = 1'b1;
        forever
        begin
            repeat (RST_CYCLES) @(posedge clk_o);
            rst_o <= 1'b0;
            @(posedge rst_req_i);
            rst_o <= 1'b1;
        end
    end

endmodule

//--- tb/tb_cam_capture.sv
`timescale 1ns/1ps

module tb_cam_capture;
    import cam_pkg::*;

    localparam int DEPTH       = 4;
    localparam int NUM_BANKS   = 3;
    localparam int SEED        = 85200;
    localparam int ACK_TIMEOUT = 20;
    localparam int RST_TIMEOUT = 40;
    localparam int NUM_TESTS   = 22;

    typedef struct {
        string       name;
        bit          rst;        // Reset DUT and model first
        int          feed;       // Words fed before the access
        bit          junk;       // Unqualified bytes between real ones
        bit          we;
        logic [8:0]  adr;
        logic [31:0] exp;
        bit          use_model;  // Expected value from the bank model
    } test_t;

    logic              PCLKI;
    logic              WBs_RST_i;
    logic              rst_req;
    logic              vsync_i;
    logic              href_i;
    logic [PIX_W-1:0]  pixel_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [ADDR_W-1:0] wb_adr_i;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack_o;

    // Bank model
    logic [DATA_W-1:0] mdl_q [NUM_BANKS][$];
    bit                mdl_ovf [NUM_BANKS];
    int                mdl_wcnt;            // Word position in the bank ring

    int run_cnt;
    int fail_cnt;
    int err_cnt;
    bit aborted;

    // --------------------
    // Test table
    // --------------------
    test_t tests [NUM_TESTS] = '{
        '{"id_read",         1'b0, 0,  1'b0, 1'b0, ID_ADR,  DEVICE_ID,     1'b0},
        '{"rev_read",        1'b0, 0,  1'b0, 1'b0, REV_ADR, 32'h0000_0100, 1'b0},
        '{"unmapped_read",   1'b0, 0,  1'b0, 1'b0, 9'h020,  DEF_REG_VALUE, 1'b0},
        '{"id_write",        1'b0, 0,  1'b0, 1'b1, ID_ADR,  32'h0,         1'b0},
        '{"id_after_write",  1'b0, 0,  1'b0, 1'b0, ID_ADR,  DEVICE_ID,     1'b0},
        '{"empty_data_read", 1'b0, 0,  1'b0, 1'b0, 9'h0C0,  32'h0,         1'b1},
        '{"empty_flag_read", 1'b0, 0,  1'b0, 1'b0, 9'h0C1,  32'h0,         1'b1},
        '{"pack_one_word",   1'b1, 1,  1'b1, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"bank0_full_flag", 1'b1, 5,  1'b1, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"bank1_flag",      1'b0, 0,  1'b0, 1'b0, 9'h081,  32'h0,         1'b1},
        '{"drain_0",         1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"drain_0_flag",    1'b0, 0,  1'b0, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"drain_1",         1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"drain_1_flag",    1'b0, 0,  1'b0, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"drain_2",         1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"drain_2_flag",    1'b0, 0,  1'b0, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"drain_3",         1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"drain_3_flag",    1'b0, 0,  1'b0, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"drained_read",    1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"wrap_ovf_flag",   1'b1, 13, 1'b0, 1'b0, 9'h041,  32'h0,         1'b1},
        '{"wrap_first_word", 1'b0, 0,  1'b0, 1'b0, 9'h040,  32'h0,         1'b1},
        '{"bank2_flag",      1'b0, 0,  1'b0, 1'b0, 9'h0C1,  32'h0,         1'b1}
    };

    tb_clk_gen #(
        .PERIOD_NS  (40),
        .RST_CYCLES (10)
    ) u_clk_gen (
        .rst_req_i  (rst_req),
        .clk_o      (PCLKI),
        .rst_o      (WBs_RST_i)
    );

    cam_capture_top #(
        .DEPTH     (DEPTH),
        .NUM_BANKS (NUM_BANKS)
    ) DUT (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .vsync_i   (vsync_i),
        .href_i    (href_i),
        .pixel_i   (pixel_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

    // --------------------
    // Model of packing and rotation
    // --------------------
    function automatic void model_reset();
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            mdl_q[b].delete();
            mdl_ovf[b] = 1'b0;
        end
        mdl_wcnt = 0;
    endfunction

    function automatic void model_push(input logic [DATA_W-1:0] word);
        int b;
        b = mdl_wcnt / DEPTH;
        if (mdl_q[b].size() == DEPTH)
            mdl_ovf[b] = 1'b1;   // Dropped word
        else
            mdl_q[b].push_back(word);
        mdl_wcnt = (mdl_wcnt + 1) % (NUM_BANKS * DEPTH);
    endfunction

    // Data reads pop the model queue like the bank does
    function automatic logic [DATA_W-1:0] model_read(input logic [8:0] adr);
        int                ofs;
        int                b;
        logic [DATA_W-1:0] val;
        ofs = int'(adr) - int'(BANK_BASE_ADR);
        b   = ofs / int'(BANK_STRIDE);
        val = '0;
        if (ofs % int'(BANK_STRIDE) == int'(FLAG_OFS))
        begin
            val[15:0]           = 16'(mdl_q[b].size());
            val[FLAG_EMPTY_BIT] = (mdl_q[b].size() == 0);
            val[FLAG_FULL_BIT]  = (mdl_q[b].size() == DEPTH);
            val[FLAG_OVF_BIT]   = mdl_ovf[b];
        end
        else if (mdl_q[b].size() > 0)
            val = mdl_q[b].pop_front();
        return val;
    endfunction

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic wait_reset(output bit released);
        int waited;
        released = 1'b0;
        waited   = 0;
        while (!released && waited < RST_TIMEOUT)
        begin
            @(negedge PCLKI);
            waited++;
            released = !WBs_RST_i;
        end
    endtask

    task automatic feed_words(input int n, input bit junk);
        logic [DATA_W-1:0] w;
        logic [PIX_W-1:0]  b;
        if (n == 0)
            return;
        for (int i = 0; i < n; i++)
        begin
            w = '0;
            for (int k = 0; k < BYTES_PER_WORD; k++)
            begin
                b = 8'($urandom);
                if (junk)
                begin
                    @(posedge PCLKI);
                    vsync_i <= (k % 2 == 0);   // One qualifier low, alternating
                    href_i  <= (k % 2 == 1);
                    pixel_i <= 8'($urandom);
                end
                @(posedge PCLKI);
                vsync_i <= 1'b1;
                href_i  <= 1'b1;
                pixel_i <= b;
                w = {w[DATA_W-PIX_W-1:0], b};
            end
            model_push(w);
        end
        @(posedge PCLKI);
        vsync_i <= 1'b0;
        href_i  <= 1'b0;
        @(posedge PCLKI);   // Last word lands in its bank
    endtask

    task automatic bus_access(input logic [8:0] adr, input bit we,
                              output logic [DATA_W-1:0] data, output bit got_ack);
        int waited;
        got_ack = 1'b0;
        data    = '0;
        waited  = 0;
        @(posedge PCLKI);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        while (!got_ack && waited < ACK_TIMEOUT)
        begin
            @(negedge PCLKI);
            waited++;
            if (wb_ack_o)
            begin
                got_ack = 1'b1;
                data    = wb_dat_o;
            end
        end
        @(posedge PCLKI);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    // --------------------
    // Test loop
    // --------------------
    initial
    begin
        bit                ok;
        bit                test_ok;
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        void'($urandom(SEED));
        rst_req  = 1'b0;
        vsync_i  = 1'b0;
        href_i   = 1'b0;
        pixel_i  = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        run_cnt  = 0;
        fail_cnt = 0;
        err_cnt  = 0;
        aborted  = 1'b0;
        model_reset();
        wait_reset(ok);
        if (!ok)
        begin
            $display("Reset did not release within %0d cycles", RST_TIMEOUT);
            aborted = 1'b1;
            fail_cnt++;
        end
        for (int t = 0; t < NUM_TESTS && !aborted; t++)
        begin
            test_ok = 1'b1;
            run_cnt++;
            if (tests[t].rst)
            begin
                @(posedge PCLKI);
                rst_req <= 1'b1;
                @(posedge PCLKI);
                rst_req <= 1'b0;
                model_reset();
                wait_reset(ok);
                if (!ok)
                begin
                    $display("%s: reset did not release within %0d cycles",
                             tests[t].name, RST_TIMEOUT);
                    aborted = 1'b1;
                    fail_cnt++;
                    break;
                end
            end
            feed_words(tests[t].feed, tests[t].junk);
            exp = tests[t].use_model ? model_read(tests[t].adr) : tests[t].exp;
            bus_access(tests[t].adr, tests[t].we, got, ok);
            if (!ok)
            begin
                $display("%s: bus ack never came within %0d cycles",
                         tests[t].name, ACK_TIMEOUT);
                aborted = 1'b1;
                fail_cnt++;
                break;
            end
            if (!tests[t].we)
            begin
                assert (got == exp)
                else
                begin
                    $display("** Error: %s expected %08h actual %08h",
                             tests[t].name, exp, got);
                    err_cnt++;
                    test_ok = 1'b0;
                end
            end
            if (!test_ok)
                fail_cnt++;
            $display("%-18s %s", tests[t].name, test_ok ? "ok" : "FAILED");
        end
        $display("Tests run %0d, failed %0d, check errors %0d", run_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && !aborted)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- sim.f
rtl/cam_pkg.sv
rtl/pixel_packer.sv
rtl/fifo_bank.sv
rtl/reg_bus.sv
rtl/cam_capture_top.sv
tb/tb_clk_gen.sv
tb/tb_cam_capture.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cam_capture -f sim.f -o sim_cam_capture
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_cam_capture)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
